// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // fetch request towards instruction memory
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    // one reply per accepted request
    typedef struct packed {
        logic  valid;
        inst_t rdata;
        logic  error;
    } mem_resp_t;

    // queue entry, also the decode-side output
    typedef struct packed {
        addr_t addr;
        inst_t inst;
        logic  error;
    } fetch_entry_t;

    // back-end restart strobe
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    // resolved branch from execute, trains the counters
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
    } br_info_t;

    // fetch unit state
    typedef enum logic [0:0] {
        IDLE,
        WAIT_RESP
    } fetch_state_e;

    // major opcodes the fetch stage looks at
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

endpackage

// ==== hw/branch_counter_table.sv ====
`timescale 1ns/100ps

module branch_counter_table #(
    parameter int BCT_INDEX_BITS = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fetch_pkg::addr_t     lookup_addr,
    output logic                 pred_taken,
    input  fetch_pkg::br_info_t  br_info
);

    localparam int ENTRIES = 1 << BCT_INDEX_BITS;

    logic [1:0]                ctr_q [ENTRIES];
    logic [BCT_INDEX_BITS-1:0] lookup_idx;
    logic [BCT_INDEX_BITS-1:0] train_idx;
    logic [1:0]                train_ctr;

    // word aligned, so skip the two low bits
    assign lookup_idx = lookup_addr[BCT_INDEX_BITS+1:2];
    assign train_idx  = br_info.pc[BCT_INDEX_BITS+1:2];
    assign train_ctr  = ctr_q[train_idx];

    // upper bit set means taken
    assign pred_taken = ctr_q[lookup_idx][1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // weakly not taken
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (br_info.valid) begin
            if (br_info.taken) begin
                if (train_ctr != 2'b11) begin
                    ctr_q[train_idx] <= train_ctr + 2'd1;
                end
            end else begin
                if (train_ctr != 2'b00) begin
                    ctr_q[train_idx] <= train_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    push,
    input  fetch_pkg::fetch_entry_t push_entry,
    output logic                    space,
    input  logic                    pop_ready,
    output logic                    pop_valid,
    output fetch_pkg::fetch_entry_t pop_entry
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_pkg::fetch_entry_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [CNT_W-1:0]        count_q;
    logic [CNT_W-1:0]        count_d;
    logic                    space_q;
    logic                    do_push;
    logic                    do_pop;

    assign pop_valid = (count_q != '0);
    assign pop_entry = mem[rd_ptr_q];
    assign space     = space_q;

    // flush wins over a push in the same cycle
    assign do_push = push && !flush;
    assign do_pop  = pop_valid && pop_ready && !flush;

    always_comb begin
        count_d = count_q;
        if (flush) begin
            count_d = '0;
        end else if (do_push && !do_pop) begin
            count_d = count_q + 1'b1;
        end else if (do_pop && !do_push) begin
            count_d = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            space_q  <= 1'b1;
        end else begin
            count_q <= count_d;
            // at least two free slots
            space_q <= (count_d <= CNT_W'(QUEUE_DEPTH - 2));
            if (flush) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (do_pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_entry;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::redirect_t    redirect,
    output fetch_pkg::mem_req_t     memreq,
    input  logic                    mem_ready,
    input  fetch_pkg::mem_resp_t    memresp,
    output fetch_pkg::addr_t        lookup_addr,
    input  logic                    pred_taken,
    output logic                    push,
    output fetch_pkg::fetch_entry_t push_entry,
    input  logic                    space,
    output logic                    flush
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::addr_t        pc_q;
    fetch_pkg::addr_t        inflight_addr_q;
    logic                    stale_q;

    logic                    resp_fire;
    fetch_pkg::inst_t        rdata;
    logic [6:0]              opcode;
    fetch_pkg::addr_t        imm_j;
    fetch_pkg::addr_t        imm_b;
    logic                    is_jal;
    logic                    is_branch;
    fetch_pkg::addr_t        seq_addr;
    fetch_pkg::addr_t        resp_next_addr;
    fetch_pkg::addr_t        req_addr;
    logic                    req_fire;

    assign resp_fire = (state_q == fetch_pkg::WAIT_RESP) && memresp.valid;
    assign rdata     = memresp.rdata;
    assign opcode    = rdata[6:0];

    // J-type and B-type immediates, sign extended, bit 0 always zero
    assign imm_j = {{11{rdata[31]}}, rdata[31], rdata[19:12], rdata[20],
                    rdata[30:21], 1'b0};
    assign imm_b = {{19{rdata[31]}}, rdata[31], rdata[7], rdata[30:25],
                    rdata[11:8], 1'b0};

    // a faulting word is never decoded
    assign is_jal    = !memresp.error && (opcode == fetch_pkg::OP_JAL);
    assign is_branch = !memresp.error && (opcode == fetch_pkg::OP_BRANCH);

    // counter table sees the address of the word coming back
    assign lookup_addr = inflight_addr_q;
    assign seq_addr    = inflight_addr_q + 32'd4;

    always_comb begin
        if (is_jal) begin
            resp_next_addr = inflight_addr_q + imm_j;
        end else if (is_branch && pred_taken) begin
            resp_next_addr = inflight_addr_q + imm_b;
        end else begin
            resp_next_addr = seq_addr;
        end
    end

    // stale reply: pc already holds the redirect target
    always_comb begin
        if (state_q == fetch_pkg::WAIT_RESP && !stale_q) begin
            req_addr = resp_next_addr;
        end else begin
            req_addr = pc_q;
        end
    end

    // idle, or the outstanding reply lands this cycle
    always_comb begin
        memreq.valid = 1'b0;
        if (!redirect.valid && space) begin
            memreq.valid = (state_q == fetch_pkg::IDLE) || memresp.valid;
        end
        memreq.addr = req_addr;
    end

    assign req_fire = memreq.valid && mem_ready;

    assign flush = redirect.valid;
    assign push  = resp_fire && !stale_q && !redirect.valid;

    always_comb begin
        push_entry.addr  = inflight_addr_q;
        push_entry.inst  = memresp.error ? fetch_pkg::INST_NOP : rdata;
        push_entry.error = memresp.error;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fetch_pkg::IDLE;
            pc_q    <= RESET_PC;
            stale_q <= 1'b0;
        end else if (redirect.valid) begin
            pc_q <= redirect.addr;
            if (state_q == fetch_pkg::WAIT_RESP && !memresp.valid) begin
                // reply still on its way, drop it when it shows up
                stale_q <= 1'b1;
            end else begin
                state_q <= fetch_pkg::IDLE;
                stale_q <= 1'b0;
            end
        end else if (state_q == fetch_pkg::IDLE) begin
            if (req_fire) begin
                state_q <= fetch_pkg::WAIT_RESP;
            end
        end else if (memresp.valid) begin
            stale_q <= 1'b0;
            if (!req_fire) begin
                // no room or memory busy, remember where to go on
                state_q <= fetch_pkg::IDLE;
                pc_q    <= req_addr;
            end
        end
    end

    // address of the request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            inflight_addr_q <= req_addr;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top #(
    parameter int              QUEUE_DEPTH    = 8,
    parameter int              BCT_INDEX_BITS = 6,
    parameter fetch_pkg::addr_t RESET_PC      = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output fetch_pkg::mem_req_t     memreq,
    input  logic                    mem_ready,
    input  fetch_pkg::mem_resp_t    memresp,
    input  fetch_pkg::redirect_t    redirect,
    input  fetch_pkg::br_info_t     br_info,
    output fetch_pkg::fetch_entry_t fetch_out,
    output logic                    fetch_valid,
    input  logic                    fetch_ready
);

    fetch_pkg::addr_t        lookup_addr;
    logic                    pred_taken;
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;
    logic                    space;
    logic                    flush;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch_unit (
        .clk(clk),
        .rst_n(rst_n),
        .redirect(redirect),
        .memreq(memreq),
        .mem_ready(mem_ready),
        .memresp(memresp),
        .lookup_addr(lookup_addr),
        .pred_taken(pred_taken),
        .push(push),
        .push_entry(push_entry),
        .space(space),
        .flush(flush)
    );

    branch_counter_table #(
        .BCT_INDEX_BITS(BCT_INDEX_BITS)
    ) u_bct (
        .clk(clk),
        .rst_n(rst_n),
        .lookup_addr(lookup_addr),
        .pred_taken(pred_taken),
        .br_info(br_info)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_inst_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush(flush),
        .push(push),
        .push_entry(push_entry),
        .space(space),
        .pop_ready(fetch_ready),
        .pop_valid(fetch_valid),
        .pop_entry(fetch_out)
    );

endmodule

// ==== dv/fetch_assertions.sv ====
`timescale 1ns/100ps

module fetch_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input fetch_pkg::mem_req_t     memreq,
    input logic                    mem_ready,
    input fetch_pkg::mem_resp_t    memresp,
    input fetch_pkg::redirect_t    redirect,
    input fetch_pkg::fetch_entry_t fetch_out,
    input logic                    fetch_valid,
    input logic                    fetch_ready
);

    logic outstanding_q;

    // set on an accepted request, cleared by its reply
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding_q <= 1'b0;
        end else if (memreq.valid && mem_ready) begin
            outstanding_q <= 1'b1;
        end else if (memresp.valid) begin
            outstanding_q <= 1'b0;
        end
    end

    single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding_q && !memresp.valid |-> !memreq.valid)
        else $error("memory request issued while a response is outstanding");

    redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |=> !fetch_valid)
        else $error("queue not empty in the cycle after a redirect");

    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_ready && !redirect.valid |=> fetch_valid && $stable(fetch_out))
        else $error("fetch output changed while stalled");

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .memreq(memreq),
    .mem_ready(mem_ready),
    .memresp(memresp),
    .redirect(redirect),
    .fetch_out(fetch_out),
    .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready)
);

// ==== dv/tb_fetch_top.sv ====
`timescale 1ns/100ps

module tb_fetch_top;

    localparam int               QUEUE_DEPTH     = 8;
    localparam int               BCT_INDEX_BITS  = 6;
    localparam fetch_pkg::addr_t RESET_PC        = 32'h0;
    localparam logic [31:0]      SEED            = 32'h5ece6c12;
    localparam int               NUM_TESTS       = 4;
    localparam int               TOTAL_ENTRIES   = 100 + 40 + 8 * 12 + 20 + 150;
    localparam int               WATCHDOG_CYCLES = 200 * TOTAL_ENTRIES * NUM_TESTS;
    localparam fetch_pkg::addr_t BR_PC           = 32'h78;

    logic                    clk = 1'b0;
    logic                    rst_n;
    fetch_pkg::mem_req_t     memreq;
    logic                    mem_ready;
    fetch_pkg::mem_resp_t    memresp;
    fetch_pkg::redirect_t    redirect;
    fetch_pkg::br_info_t     br_info;
    fetch_pkg::fetch_entry_t fetch_out;
    logic                    fetch_valid;
    logic                    fetch_ready;

    fetch_pkg::inst_t prog [256];
    logic             err_tab [256];
    logic [1:0]       ctr_model [1 << BCT_INDEX_BITS];
    logic [31:0]      mem_rng;
    logic [31:0]      stim_rng;
    fetch_pkg::addr_t exp_addr;
    string            test_name;
    int               pops;
    int               ready_mode;
    int               hold_cnt;
    int               addr_errs;
    int               inst_errs;
    int               flag_errs;

    fetch_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .BCT_INDEX_BITS(BCT_INDEX_BITS),
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .memreq(memreq),
        .mem_ready(mem_ready),
        .memresp(memresp),
        .redirect(redirect),
        .br_info(br_info),
        .fetch_out(fetch_out),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic fetch_pkg::inst_t enc_jal(input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, fetch_pkg::OP_JAL};
    endfunction

    // beq x1, x2, off
    function automatic fetch_pkg::inst_t enc_branch(input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], fetch_pkg::OP_BRANCH};
    endfunction

    // expected successor of one fetched word
    function automatic fetch_pkg::addr_t ref_next_pc(input fetch_pkg::addr_t pc,
                                                     input fetch_pkg::inst_t w,
                                                     input logic err);
        fetch_pkg::addr_t imm;
        if (!err && w[6:0] == fetch_pkg::OP_JAL) begin
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            return pc + imm;
        end
        if (!err && w[6:0] == fetch_pkg::OP_BRANCH && ctr_model[pc[BCT_INDEX_BITS+1:2]][1]) begin
            imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic print_summary();
        $display("check summary: addr %0d, inst %0d, fault flag %0d mismatches",
                 addr_errs, inst_errs, flag_errs);
    endtask

    // ready modes are 0 always, 1 random and 2 long stalls
    task automatic drive_ready();
        if (ready_mode == 0) begin
            fetch_ready = 1'b1;
        end else if (hold_cnt != 0) begin
            hold_cnt--;
        end else begin
            stim_rng = lcg_step(stim_rng);
            if (ready_mode == 1) begin
                fetch_ready = stim_rng[31:30] != 2'b00;
            end else begin
                fetch_ready = !fetch_ready;
                hold_cnt = fetch_ready ? int'(stim_rng[27:26]) : 10 + int'(stim_rng[28:24]);
            end
        end
    endtask

    task automatic wait_pops(input int n);
        int target;
        target = pops + n;
        while (pops < target) begin
            drive_ready();
            step();
        end
    endtask

    task automatic train_branch(input fetch_pkg::addr_t pc, input logic taken);
        br_info.valid = 1'b1;
        br_info.pc    = pc;
        br_info.taken = taken;
        step();
        br_info = '0;
    endtask

    task automatic send_redirect(input fetch_pkg::addr_t target);
        redirect.valid = 1'b1;
        redirect.addr  = target;
        step();
        redirect = '0;
    endtask

    // instruction memory with one request at a time and 1 to 3 cycles latency
    always begin : mem_model
        logic             accept;
        logic             in_reset;
        logic             pend;
        int               wait_cnt;
        fetch_pkg::addr_t acc_addr;
        fetch_pkg::addr_t pend_addr;
        @(negedge clk);
        in_reset = !rst_n;
        accept   = rst_n && memreq.valid && mem_ready;
        acc_addr = memreq.addr;
        @(posedge clk);
        #2;
        if (in_reset) begin
            pend      = 1'b0;
            memresp   = '0;
            mem_ready = 1'b0;
        end else begin
            memresp.valid = 1'b0;
            if (accept) begin
                pend      = 1'b1;
                pend_addr = acc_addr;
                mem_rng   = lcg_step(mem_rng);
                wait_cnt  = int'(mem_rng[23:16]) % 3;
            end
            if (pend && wait_cnt == 0) begin
                pend          = 1'b0;
                memresp.valid = 1'b1;
                memresp.rdata = prog[pend_addr[9:2]];
                memresp.error = err_tab[pend_addr[9:2]];
            end else if (pend) begin
                wait_cnt--;
            end
            mem_rng   = lcg_step(mem_rng);
            mem_ready = mem_rng[31:29] != 3'b000;
        end
    end

    // sampled mid cycle before the pop edge
    always begin : compare
        fetch_pkg::inst_t          exp_inst;
        logic                      exp_err;
        logic [BCT_INDEX_BITS-1:0] idx;
        @(negedge clk);
        if (rst_n && redirect.valid) begin
            exp_addr = redirect.addr;
        end else if (rst_n && fetch_valid && fetch_ready) begin
            exp_err  = err_tab[exp_addr[9:2]];
            exp_inst = exp_err ? fetch_pkg::INST_NOP : prog[exp_addr[9:2]];
            assert (fetch_out.addr == exp_addr) else begin
                $display("error %s addr: expected %h, actual %h", test_name, exp_addr,
                         fetch_out.addr);
                addr_errs++;
            end
            assert (fetch_out.inst == exp_inst) else begin
                $display("error %s inst: expected %h, actual %h", test_name, exp_inst,
                         fetch_out.inst);
                inst_errs++;
            end
            assert (fetch_out.error == exp_err) else begin
                $display("error %s fault flag: expected %b, actual %b", test_name, exp_err,
                         fetch_out.error);
                flag_errs++;
            end
            exp_addr = ref_next_pc(exp_addr, exp_inst, exp_err);
            pops++;
        end
        if (rst_n && br_info.valid) begin
            idx = br_info.pc[BCT_INDEX_BITS+1:2];
            if (br_info.taken && ctr_model[idx] != 2'b11) begin
                ctr_model[idx] = ctr_model[idx] + 2'd1;
            end else if (!br_info.taken && ctr_model[idx] != 2'b00) begin
                ctr_model[idx] = ctr_model[idx] - 2'd1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: expected entries did not arrive within %0d cycles",
                 WATCHDOG_CYCLES);
        print_summary();
        $display("Test failures found");
        $finish;
    end

    initial begin
        fetch_pkg::addr_t target;
        rst_n       = 1'b0;
        mem_ready   = 1'b0;
        memresp     = '0;
        redirect    = '0;
        br_info     = '0;
        fetch_ready = 1'b0;
        mem_rng     = SEED;
        stim_rng    = lcg_step(SEED);
        exp_addr    = RESET_PC;
        pops        = 0;
        ready_mode  = 0;
        hold_cnt    = 0;
        addr_errs   = 0;
        inst_errs   = 0;
        flag_errs   = 0;
        // addi rd, x0, index
        for (int i = 0; i < 256; i++) begin
            prog[i]    = {12'(i), 5'd0, 3'd0, 5'(i % 31 + 1), 7'h13};
            err_tab[i] = 1'b0;
        end
        for (int i = 0; i < (1 << BCT_INDEX_BITS); i++) begin
            ctr_model[i] = 2'b01;
        end
        prog[10]    = enc_jal(32'h40);
        prog[30]    = enc_branch(32'h20);
        prog[50]    = enc_branch(-32);
        prog[60]    = enc_jal(-240);
        // a faulting jal still falls through to pc+4
        prog[40]    = enc_jal(-160);
        err_tab[40] = 1'b1;
        err_tab[100] = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_name  = "seq_fetch";
        ready_mode = 1;
        wait_pops(100);

        // train with decode stalled and then jump back ahead of the branch
        test_name   = "branch_trained";
        ready_mode  = 0;
        fetch_ready = 1'b0;
        repeat (4) step();
        train_branch(BR_PC, 1'b1);
        train_branch(BR_PC, 1'b1);
        send_redirect(32'h68);
        wait_pops(40);

        test_name  = "redirect";
        ready_mode = 1;
        for (int r = 0; r < 8; r++) begin
            wait_pops(12);
            stim_rng = lcg_step(stim_rng);
            target   = {22'd0, stim_rng[15:8], 2'b00};
            send_redirect(target);
        end
        wait_pops(20);

        test_name  = "back_pressure";
        ready_mode = 2;
        wait_pops(150);

        step();
        print_summary();
        if (addr_errs + inst_errs + flag_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/fetch_pkg.sv
hw/branch_counter_table.sv
hw/inst_queue.sv
hw/fetch_unit.sv
hw/fetch_top.sv
dv/fetch_assertions.sv
dv/tb_fetch_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_fetch_top
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
